// ==== hw/motion_pkg.sv ====
package motion_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 5;
    localparam int POS_W  = 64;   // 32.32 fixed point, upper half is whole steps
    localparam int CNT_W  = 32;

    // Register map
    localparam logic [ADDR_W-1:0] REG_STEPS  = ADDR_W'(0);
    localparam logic [ADDR_W-1:0] REG_DT     = ADDR_W'(1);
    localparam logic [ADDR_W-1:0] REG_PRE    = ADDR_W'(2);
    localparam logic [ADDR_W-1:0] REG_PULSE  = ADDR_W'(3);
    localparam logic [ADDR_W-1:0] REG_POST   = ADDR_W'(4);
    localparam logic [ADDR_W-1:0] REG_ENABLE = ADDR_W'(5);
    localparam logic [ADDR_W-1:0] REG_GO     = ADDR_W'(6);
    localparam int REG_AXIS_BASE = 8;   // v at base + 2n, a at base + 2n + 1

    typedef struct packed {
        logic [CNT_W-1:0] steps;
        logic [CNT_W-1:0] dt;
    } timing_cfg_t;

    typedef struct packed {
        logic [CNT_W-1:0] pre_n;
        logic [CNT_W-1:0] pulse_n;
        logic [CNT_W-1:0] post_n;
    } pulse_cfg_t;

    typedef struct packed {
        logic signed [DATA_W-1:0] v;
        logic signed [DATA_W-1:0] a;
    } axis_cfg_t;

    typedef struct packed {
        logic step;
        logic dir;
        logic enable_n;
    } motor_t;

endpackage

// ==== hw/motion_regs.sv ====
`timescale 1ns/1ps

module motion_regs import motion_pkg::*; #(
    parameter int NUM_AXES = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              reg_wr,
    input  logic [ADDR_W-1:0] reg_addr,
    input  logic [DATA_W-1:0] reg_data,
    output timing_cfg_t       timing,
    output pulse_cfg_t        pulse,
    output axis_cfg_t         axis [NUM_AXES],
    output logic [NUM_AXES-1:0] enable,
    output logic              load
);

    always_ff @(posedge clk) begin
        if (rst) begin
            timing <= '0;
            pulse  <= '0;
            enable <= '0;
            load   <= 1'b0;
            for (int n = 0; n < NUM_AXES; n++) begin
                axis[n] <= '0;
            end
        end else begin
            load <= reg_wr && (reg_addr == REG_GO);   // GO data is don't care

            if (reg_wr) begin
                case (reg_addr)
                    REG_STEPS:  timing.steps  <= reg_data;
                    REG_DT:     timing.dt     <= reg_data;
                    REG_PRE:    pulse.pre_n   <= reg_data;
                    REG_PULSE:  pulse.pulse_n <= reg_data;
                    REG_POST:   pulse.post_n  <= reg_data;
                    REG_ENABLE: enable        <= reg_data[NUM_AXES-1:0];
                    default: ;
                endcase

                // Per-axis velocity and acceleration pairs
                for (int n = 0; n < NUM_AXES; n++) begin
                    if (reg_addr == ADDR_W'(REG_AXIS_BASE + 2 * n)) begin
                        axis[n].v <= reg_data;
                    end
                    if (reg_addr == ADDR_W'(REG_AXIS_BASE + 2 * n + 1)) begin
                        axis[n].a <= reg_data;
                    end
                end
            end
        end
    end

endmodule

// ==== hw/tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen import motion_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        load,
    input  timing_cfg_t timing,
    output logic        tick,
    output logic        busy,
    output logic        done
);

    logic [CNT_W-1:0] dt_eff;
    logic [CNT_W-1:0] dt_q;       // period latched at load
    logic [CNT_W-1:0] period_cnt;
    logic [CNT_W-1:0] remain;

    assign dt_eff = (timing.dt == '0) ? CNT_W'(1) : timing.dt;

    // Tick on the last cycle of each period
    assign tick = busy && (period_cnt == CNT_W'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            dt_q       <= '0;
            period_cnt <= '0;
            remain     <= '0;
        end else begin
            done <= 1'b0;
            if (load) begin
                dt_q       <= dt_eff;
                period_cnt <= dt_eff;
                remain     <= timing.steps;
                busy       <= (timing.steps != '0);
                done       <= (timing.steps == '0);   // empty move
            end else if (busy) begin
                if (tick) begin
                    period_cnt <= dt_q;
                    remain     <= remain - 1'b1;
                    if (remain == CNT_W'(1)) begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end else begin
                    period_cnt <= period_cnt - 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/profile_gen.sv ====
`timescale 1ns/1ps

module profile_gen import motion_pkg::*; #(
    parameter int STEP_BIT = 32
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      load,
    input  logic      tick,
    input  axis_cfg_t cfg,
    output logic      step_stb,
    output logic      step_dir
);

    logic signed [POS_W-1:0]  pos;
    logic signed [POS_W-1:0]  pos_next;
    logic signed [DATA_W-1:0] vel;
    logic signed [DATA_W-1:0] acc;

    // Velocity sign-extended into the 32.32 position
    assign pos_next = pos + {{(POS_W - DATA_W){vel[DATA_W-1]}}, vel};

    always_ff @(posedge clk) begin
        if (rst) begin
            pos      <= '0;
            vel      <= '0;
            acc      <= '0;
            step_stb <= 1'b0;
            step_dir <= 1'b0;
        end else begin
            step_stb <= 1'b0;
            if (load) begin
                pos <= '0;
                vel <= cfg.v;
                acc <= cfg.a;
            end else if (tick) begin
                pos      <= pos_next;
                vel      <= vel + acc;   // old velocity drives this tick
                step_stb <= pos_next[STEP_BIT] != pos[STEP_BIT];
                step_dir <= vel[DATA_W-1];
            end
        end
    end

endmodule

// ==== hw/step_pulse.sv ====
`timescale 1ns/1ps

module step_pulse import motion_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       step_stb,
    input  logic       step_dir,
    input  pulse_cfg_t cfg,
    input  logic       enable,
    output motor_t     motor
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_PRE,
        S_PULSE,
        S_POST
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] pulse_eff;

    assign pulse_eff = (cfg.pulse_n == '0) ? CNT_W'(1) : cfg.pulse_n;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
            motor <= '{step: 1'b0, dir: 1'b0, enable_n: 1'b1};
        end else begin
            motor.enable_n <= ~enable;
            case (state)
                S_IDLE: begin
                    if (step_stb) begin
                        motor.dir <= step_dir;
                        if (cfg.pre_n == '0) begin   // no setup time
                            state      <= S_PULSE;
                            motor.step <= 1'b1;
                            cnt        <= pulse_eff;
                        end else begin
                            state <= S_PRE;
                            cnt   <= cfg.pre_n;
                        end
                    end
                end
                S_PRE: begin
                    if (cnt == CNT_W'(1)) begin
                        state      <= S_PULSE;
                        motor.step <= 1'b1;
                        cnt        <= pulse_eff;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                S_PULSE: begin
                    if (cnt == CNT_W'(1)) begin
                        motor.step <= 1'b0;
                        cnt        <= cfg.post_n;
                        state      <= (cfg.post_n == '0) ? S_IDLE : S_POST;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                S_POST: begin
                    if (cnt == CNT_W'(1)) begin
                        state <= S_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/motion_top.sv ====
`timescale 1ns/1ps

module motion_top import motion_pkg::*; #(
    parameter int NUM_AXES = 3,
    parameter int STEP_BIT = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              reg_wr,
    input  logic [ADDR_W-1:0] reg_addr,
    input  logic [DATA_W-1:0] reg_data,
    output motor_t            motor [NUM_AXES],
    output logic              busy,
    output logic              done
);

    timing_cfg_t         timing;
    pulse_cfg_t          pulse;
    axis_cfg_t           axis [NUM_AXES];
    logic [NUM_AXES-1:0] enable;
    logic                load;
    logic                tick;
    logic [NUM_AXES-1:0] step_stb;
    logic [NUM_AXES-1:0] step_dir;

    motion_regs #(.NUM_AXES(NUM_AXES)) u_regs (
        .clk(clk),
        .rst(rst),
        .reg_wr(reg_wr),
        .reg_addr(reg_addr),
        .reg_data(reg_data),
        .timing(timing),
        .pulse(pulse),
        .axis(axis),
        .enable(enable),
        .load(load)
    );

    tick_gen u_tick (
        .clk(clk),
        .rst(rst),
        .load(load),
        .timing(timing),
        .tick(tick),
        .busy(busy),
        .done(done)
    );

    // One integrator and one pulse shaper per axis
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        profile_gen #(.STEP_BIT(STEP_BIT)) u_prof (
            .clk(clk),
            .rst(rst),
            .load(load),
            .tick(tick),
            .cfg(axis[i]),
            .step_stb(step_stb[i]),
            .step_dir(step_dir[i])
        );

        step_pulse u_pulse (
            .clk(clk),
            .rst(rst),
            .step_stb(step_stb[i]),
            .step_dir(step_dir[i]),
            .cfg(pulse),
            .enable(enable[i]),
            .motor(motor[i])
        );
    end

endmodule

// ==== sim/motion_chk.sv ====
`timescale 1ns/1ps

module motion_chk import motion_pkg::*; (
    input logic       clk,
    input logic       rst,
    input pulse_cfg_t cfg,
    input motor_t     motor
);

    logic [CNT_W-1:0] low_cnt;   // Cycles since step was last high

    always_ff @(posedge clk) begin
        if (rst) begin
            low_cnt <= '1;
        end else if (motor.step) begin
            low_cnt <= '0;
        end else if (low_cnt != '1) begin
            low_cnt <= low_cnt + 1'b1;
        end
    end

    // Hold time after a pulse before the next one
    assert property (@(posedge clk) disable iff (rst)
        $rose(motor.step) |-> low_cnt > cfg.post_n)
        else $error("step rose after %0d low cycles, post_n is %0d", low_cnt, cfg.post_n);

    assert property (@(posedge clk) disable iff (rst)
        motor.step && $past(motor.step) |-> $stable(motor.dir))
        else $error("dir changed while step was high");

endmodule

bind step_pulse motion_chk u_chk (
    .clk(clk),
    .rst(rst),
    .cfg(cfg),
    .motor(motor)
);

// ==== sim/motion_tb.sv ====
`timescale 1ns/1ps

module motion_tb import motion_pkg::*; ();

    localparam int NUM_AXES  = 3;
    localparam int MAX_STEPS = 32;
    localparam logic [15:0] LFSR_SEED = 16'd61;
    localparam logic [NUM_AXES-1:0] EN_PATTERN = 3'b101;

    logic                clk;
    logic                rst;
    logic                reg_wr;
    logic [ADDR_W-1:0]   reg_addr;
    logic [DATA_W-1:0]   reg_data;
    motor_t              motor [NUM_AXES];
    logic                busy;
    logic                done;

    logic [15:0] lfsr;
    int          errors;
    int          timeouts;
    int          done_cnt;
    int          exp_high;              // Expected step high time in cycles
    int          step_cnt [NUM_AXES];
    int          exp_cnt [NUM_AXES];
    int          high_cnt [NUM_AXES];
    logic        prev_step [NUM_AXES];
    logic        exp_last [NUM_AXES];
    logic        exp_dir [NUM_AXES][MAX_STEPS];

    motion_top #(.NUM_AXES(NUM_AXES), .STEP_BIT(32)) u_dut (
        .clk(clk),
        .rst(rst),
        .reg_wr(reg_wr),
        .reg_addr(reg_addr),
        .reg_data(reg_data),
        .motor(motor),
        .busy(busy),
        .done(done)
    );

    always #20 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    // Magnitude 2^29 plus 29 random bits, random sign
    function automatic logic signed [31:0] random_velocity();
        logic signed [31:0] mag;
        mag = 32'sh2000_0000;
        for (int i = 0; i < 29; i++) begin
            mag[i] = lfsr_bit();
        end
        return lfsr_bit() ? -mag : mag;
    endfunction

    function automatic logic signed [31:0] random_signed(input int n);
        logic signed [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[30:0], lfsr_bit()};
        end
        w = w <<< (32 - n);
        return w >>> (32 - n);
    endfunction

    // Replays the tick rule: pos += v, v += a; a step whenever the unit bit flips
    function automatic int ref_steps(input int ax, input logic signed [31:0] v,
                                     input logic signed [31:0] a, input int steps,
                                     output logic last_dir);
        longint             pos;
        longint             nxt;
        logic signed [31:0] vel;
        int                 n;
        pos = 0;
        vel = v;
        n = 0;
        last_dir = 1'b0;
        for (int t = 0; t < steps; t++) begin
            nxt = pos + longint'(vel);
            if (nxt[32] != pos[32]) begin
                if (n < MAX_STEPS) exp_dir[ax][n] = (vel < 0);
                last_dir = (vel < 0);
                n++;
            end
            pos = nxt;
            vel = vel + a;
        end
        return n;
    endfunction

    task automatic report_mismatch(input string name, input longint exp, input longint act);
        $display("FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        errors++;
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        reg_wr   <= 1'b1;
        reg_addr <= addr;
        reg_data <= data;
        @(posedge clk);
        reg_wr   <= 1'b0;
    endtask

    task automatic set_pulse(input int pre_n, input int pulse_n, input int post_n);
        write_reg(REG_PRE, 32'(pre_n));
        write_reg(REG_PULSE, 32'(pulse_n));
        write_reg(REG_POST, 32'(post_n));
        exp_high = (pulse_n == 0) ? 1 : pulse_n;
    endtask

    task automatic run_move(input int steps, input int dt, input bit accel);
        logic signed [31:0] v;
        logic signed [31:0] a;
        int                 cycles;
        int                 limit;
        for (int ax = 0; ax < NUM_AXES; ax++) begin
            v = random_velocity();
            a = accel ? random_signed(24) : '0;
            if (accel && ax == 0) begin   // Forced zero crossing of velocity
                v = 32'sh4000_0000 | (random_signed(28) & 32'sh0fff_ffff);
                a = -(v >>> 3);
            end
            write_reg(ADDR_W'(REG_AXIS_BASE + 2 * ax), v);
            write_reg(ADDR_W'(REG_AXIS_BASE + 2 * ax + 1), a);
            exp_cnt[ax] = ref_steps(ax, v, a, steps, exp_last[ax]);
            step_cnt[ax] = 0;
        end
        write_reg(REG_STEPS, 32'(steps));
        write_reg(REG_DT, 32'(dt));
        done_cnt = 0;
        write_reg(REG_GO, '0);
        cycles = 1;   // Counted from the cycle that carries the GO write
        limit = steps * dt + 50;
        @(negedge clk);
        while (done !== 1'b1 && cycles < limit) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        if (done !== 1'b1) begin
            $display("Timeout: no done pulse within %0d cycles of GO", limit);
            timeouts++;
        end else if (cycles != steps * dt + 2) begin
            report_mismatch("GO-to-done cycles", steps * dt + 2, cycles);
        end
        repeat (20) @(negedge clk);   // Let the last pulse finish
        if (busy !== 1'b0) report_mismatch("busy", 0, busy);
        if (done_cnt != 1) report_mismatch("done pulse count", 1, done_cnt);
        for (int ax = 0; ax < NUM_AXES; ax++) begin
            if (step_cnt[ax] != exp_cnt[ax])
                report_mismatch($sformatf("motor[%0d].step count", ax), exp_cnt[ax],
                                step_cnt[ax]);
            if (exp_cnt[ax] > 0 && motor[ax].dir !== exp_last[ax])
                report_mismatch($sformatf("motor[%0d].dir final", ax), exp_last[ax],
                                motor[ax].dir);
        end
    endtask

    // Step, dir and pulse width monitor
    always @(negedge clk) begin
        if (done === 1'b1) done_cnt++;
        for (int ax = 0; ax < NUM_AXES; ax++) begin
            if (motor[ax].step === 1'b1) begin
                if (!prev_step[ax]) begin
                    if (step_cnt[ax] < exp_cnt[ax] && step_cnt[ax] < MAX_STEPS &&
                        motor[ax].dir !== exp_dir[ax][step_cnt[ax]])
                        report_mismatch($sformatf("motor[%0d].dir", ax),
                                        exp_dir[ax][step_cnt[ax]], motor[ax].dir);
                    step_cnt[ax]++;
                    high_cnt[ax] = 0;
                end
                high_cnt[ax]++;
            end else if (prev_step[ax] && high_cnt[ax] != exp_high) begin
                report_mismatch($sformatf("motor[%0d].step high cycles", ax), exp_high,
                                high_cnt[ax]);
            end
            prev_step[ax] = (motor[ax].step === 1'b1);
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        reg_wr = 1'b0;
        reg_addr = '0;
        reg_data = '0;
        lfsr = LFSR_SEED;
        errors = 0;
        timeouts = 0;
        done_cnt = 0;
        exp_high = 1;
        for (int ax = 0; ax < NUM_AXES; ax++) begin
            step_cnt[ax] = 0;
            exp_cnt[ax] = 0;
            high_cnt[ax] = 0;
            prev_step[ax] = 1'b0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        if (busy !== 1'b0) report_mismatch("busy", 0, busy);
        if (done !== 1'b0) report_mismatch("done", 0, done);
        for (int ax = 0; ax < NUM_AXES; ax++) begin
            if (motor[ax].step !== 1'b0)
                report_mismatch($sformatf("motor[%0d].step", ax), 0, motor[ax].step);
            if (motor[ax].enable_n !== 1'b1)
                report_mismatch($sformatf("motor[%0d].enable_n", ax), 1, motor[ax].enable_n);
        end

        write_reg(REG_ENABLE, 32'(EN_PATTERN));
        @(posedge clk);
        @(negedge clk);
        for (int ax = 0; ax < NUM_AXES; ax++) begin
            if (motor[ax].enable_n !== !EN_PATTERN[ax])   // Pattern 101 enables even axes
                report_mismatch($sformatf("motor[%0d].enable_n", ax), !EN_PATTERN[ax],
                                motor[ax].enable_n);
        end
        write_reg(REG_ENABLE, 32'h7);

        set_pulse(2, 3, 2);
        run_move(24, 12, 1'b0);
        set_pulse(1, 0, 1);
        run_move(16, 10, 1'b1);
        run_move(0, 12, 1'b0);

        $display("Errors: %0d value mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hw/motion_pkg.sv
hw/motion_regs.sv
hw/tick_gen.sv
hw/profile_gen.sv
hw/step_pulse.sv
hw/motion_top.sv
sim/motion_chk.sv
sim/motion_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the motion controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module motion_tb \
    -f sim.f -Mdir obj_dir -o motion_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/motion_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test OK" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
